// ==== nn_cfg.svh ====
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

// fixed-point word, Q8.8
`define NN_N_LEN 16
`define NN_F_LEN 8

// lanes fed to the core per cycle
`define NN_LANES 6

// layer shape
`define NN_IN_DIM 24
`define NN_HID_DIM 24

// input dimension over lanes
`define NN_CHUNKS 4

// host address map
`define NN_ADDR_W 10
// weights sit below the bias base at neuron * 24 + input
`define NN_BIAS_BASE 576
`define NN_INPUT_BASE 600

`endif

// ==== nn_pkg.sv ====
`include "nn_cfg.svh"

package nn_pkg;

  // signed Q8.8 value
  typedef logic signed [`NN_N_LEN-1:0] fix_t;

  // sequencer control state
  typedef enum logic {
    seq_idle = 1'b0,
    seq_run  = 1'b1
  } seq_state_t;

endpackage

// ==== layer_bus_if.sv ====
`include "nn_cfg.svh"

interface layer_bus_if;

  // one chunk of inputs and matching weights
  nn_pkg::fix_t data_lanes [`NN_LANES];
  nn_pkg::fix_t weight_lanes [`NN_LANES];

  // bias for the neuron being captured
  nn_pkg::fix_t bias;
  logic [$clog2(`NN_HID_DIM)-1:0] bias_idx;

  // run level from the sequencer, end of run from the core
  logic run;
  logic valid;

  modport regs (
    output data_lanes,
    output weight_lanes,
    output bias,
    input  bias_idx
  );

  modport seq (
    output run,
    input  valid
  );

  modport core (
    input  data_lanes,
    input  weight_lanes,
    input  bias,
    input  run,
    output bias_idx,
    output valid
  );

  modport monitor (
    input data_lanes,
    input weight_lanes,
    input bias,
    input bias_idx,
    input run,
    input valid
  );

endinterface

// ==== param_regs.sv ====
`include "nn_cfg.svh"

module param_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             wr_en,
  input  logic [`NN_ADDR_W-1:0]            wr_addr,
  input  nn_pkg::fix_t                     wr_data,
  input  logic                             busy,
  input  logic [$clog2(`NN_HID_DIM)-1:0]   neuron_idx,
  input  logic [$clog2(`NN_CHUNKS)-1:0]    chunk_idx,
  layer_bus_if.regs                        bus
);

  localparam int w_depth = `NN_IN_DIM * `NN_HID_DIM;
  localparam int in_w = $clog2(`NN_IN_DIM);
  localparam int hid_w = $clog2(`NN_HID_DIM);
  localparam logic [`NN_ADDR_W-1:0] bias_base = `NN_BIAS_BASE;
  localparam logic [`NN_ADDR_W-1:0] input_base = `NN_INPUT_BASE;
  localparam logic [`NN_ADDR_W-1:0] addr_end = `NN_INPUT_BASE + `NN_IN_DIM;

  nn_pkg::fix_t weight_mem [w_depth];
  nn_pkg::fix_t bias_mem [`NN_HID_DIM];
  nn_pkg::fix_t input_mem [`NN_IN_DIM];

  logic [`NN_ADDR_W-1:0] bias_off;
  logic [`NN_ADDR_W-1:0] input_off;
  logic [in_w-1:0]       chunk_base;
  logic [`NN_ADDR_W-1:0] weight_base;

  // offsets into the bias and input windows
  assign bias_off = wr_addr - bias_base;
  assign input_off = wr_addr - input_base;

  // host writes, dropped while a run is active
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < w_depth; i++) begin
        weight_mem[i] <= '0;
      end
      for (int i = 0; i < `NN_HID_DIM; i++) begin
        bias_mem[i] <= '0;
      end
      for (int i = 0; i < `NN_IN_DIM; i++) begin
        input_mem[i] <= '0;
      end
    end else if (wr_en && !busy) begin
      if (wr_addr < bias_base) begin
        weight_mem[wr_addr] <= wr_data;
      end else if (wr_addr < input_base) begin
        bias_mem[bias_off[hid_w-1:0]] <= wr_data;
      end else if (wr_addr < addr_end) begin
        input_mem[input_off[in_w-1:0]] <= wr_data;
      end
    end
  end

  // first input of the chunk, and first weight of that chunk for the neuron
  assign chunk_base = chunk_idx * in_w'(`NN_LANES);
  assign weight_base = `NN_ADDR_W'(neuron_idx) * `NN_ADDR_W'(`NN_IN_DIM)
                     + `NN_ADDR_W'(chunk_base);

  genvar g;
  generate
    for (g = 0; g < `NN_LANES; g++) begin : g_lane
      assign bus.data_lanes[g] = input_mem[chunk_base + in_w'(g)];
      assign bus.weight_lanes[g] = weight_mem[weight_base + `NN_ADDR_W'(g)];
    end
  endgenerate

  // core index runs one past the last neuron once all results are in
  assign bus.bias = (int'(bus.bias_idx) < `NN_HID_DIM) ? bias_mem[bus.bias_idx] : '0;

endmodule

// ==== layer_sequencer.sv ====
`include "nn_cfg.svh"

module layer_sequencer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  output logic                             busy,
  output logic                             done,
  output logic [$clog2(`NN_HID_DIM)-1:0]   neuron_idx,
  output logic [$clog2(`NN_CHUNKS)-1:0]    chunk_idx,
  layer_bus_if.seq                         bus
);

  localparam int chunk_w = $clog2(`NN_CHUNKS);
  localparam int step_w = $clog2(`NN_HID_DIM * `NN_CHUNKS);
  localparam logic [step_w-1:0] last_step = step_w'(`NN_HID_DIM * `NN_CHUNKS - 1);

  nn_pkg::seq_state_t state;
  logic [step_w-1:0]  step;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= nn_pkg::seq_idle;
      step <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        nn_pkg::seq_idle: begin
          step <= '0;
          if (start) begin
            state <= nn_pkg::seq_run;
          end
        end
        nn_pkg::seq_run: begin
          if (bus.valid) begin
            // last result is stored, close the run
            state <= nn_pkg::seq_idle;
            step <= '0;
            done <= 1'b1;
          end else if (step != last_step) begin
            step <= step + 1'b1;
          end
        end
        default: begin
          state <= nn_pkg::seq_idle;
        end
      endcase
    end
  end

  assign busy = (state == nn_pkg::seq_run);
  assign bus.run = busy;

  // low bits walk the chunks, high bits the neurons
  assign neuron_idx = step[step_w-1:chunk_w];
  assign chunk_idx = step[chunk_w-1:0];

endmodule

// ==== dense_core.sv ====
`include "nn_cfg.svh"

module dense_core (
  input  logic                                clk,
  input  logic                                rst_n,
  layer_bus_if.core                           bus,
  output logic [`NN_HID_DIM*`NN_N_LEN-1:0]    results
);

  localparam int slot_w = $clog2(`NN_CHUNKS);
  localparam int idx_w = $clog2(`NN_HID_DIM);
  // first full sum sits in tree_sum while the count is 9
  localparam int first_cap = 9;
  localparam int last_cnt = first_cap + `NN_CHUNKS * (`NN_HID_DIM - 1) + 1;
  localparam int cnt_w = $clog2(last_cnt + 1);

  nn_pkg::fix_t lane_data [`NN_LANES];
  nn_pkg::fix_t lane_weight [`NN_LANES];
  nn_pkg::fix_t prod [`NN_LANES];
  nn_pkg::fix_t pair_sum [3];
  nn_pkg::fix_t slot [`NN_CHUNKS];
  nn_pkg::fix_t half_sum [2];
  nn_pkg::fix_t tree_sum;
  nn_pkg::fix_t res_mem [`NN_HID_DIM];

  logic [slot_w-1:0] slot_ptr;
  logic [cnt_w-1:0]  run_cnt;
  logic [cnt_w-1:0]  cap_cnt;
  logic [idx_w-1:0]  res_idx;
  logic              cap_hit;

  // Q8.8 multiply, keeps product bits 8 to 23
  function automatic nn_pkg::fix_t fx_mul(nn_pkg::fix_t a, nn_pkg::fix_t b);
    logic signed [2*`NN_N_LEN-1:0] full;
    full = a * b;
    return full[`NN_F_LEN +: `NN_N_LEN];
  endfunction

  // datapath, flushed whenever run is low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NN_LANES; i++) begin
        lane_data[i] <= '0;
        lane_weight[i] <= '0;
        prod[i] <= '0;
      end
      for (int i = 0; i < 3; i++) begin
        pair_sum[i] <= '0;
      end
      for (int i = 0; i < `NN_CHUNKS; i++) begin
        slot[i] <= '0;
      end
      half_sum[0] <= '0;
      half_sum[1] <= '0;
      tree_sum <= '0;
      slot_ptr <= '0;
    end else if (!bus.run) begin
      for (int i = 0; i < `NN_LANES; i++) begin
        lane_data[i] <= '0;
        lane_weight[i] <= '0;
        prod[i] <= '0;
      end
      for (int i = 0; i < 3; i++) begin
        pair_sum[i] <= '0;
      end
      for (int i = 0; i < `NN_CHUNKS; i++) begin
        slot[i] <= '0;
      end
      half_sum[0] <= '0;
      half_sum[1] <= '0;
      tree_sum <= '0;
      slot_ptr <= '0;
    end else begin
      // lane capture, then product stage
      for (int i = 0; i < `NN_LANES; i++) begin
        lane_data[i] <= bus.data_lanes[i];
        lane_weight[i] <= bus.weight_lanes[i];
        prod[i] <= fx_mul(lane_data[i], lane_weight[i]);
      end
      for (int i = 0; i < 3; i++) begin
        pair_sum[i] <= prod[2*i] + prod[2*i+1];
      end
      // chunk sum rotates through the slots
      slot_ptr <= slot_ptr + 1'b1;
      slot[slot_ptr] <= pair_sum[0] + pair_sum[1] + pair_sum[2];
      half_sum[0] <= slot[0] + slot[1];
      half_sum[1] <= slot[2] + slot[3];
      tree_sum <= half_sum[0] + half_sum[1];
    end
  end

  // slots hold one whole neuron every fourth cycle
  assign cap_hit = bus.run && (run_cnt == cap_cnt + cnt_w'(first_cap));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_cnt <= '0;
      cap_cnt <= '0;
      res_idx <= '0;
    end else if (bus.run) begin
      if (run_cnt != cnt_w'(last_cnt)) begin
        run_cnt <= run_cnt + 1'b1;
      end
      if (cap_hit) begin
        cap_cnt <= cap_cnt + cnt_w'(`NN_CHUNKS);
        res_idx <= res_idx + 1'b1;
      end
    end else begin
      run_cnt <= '0;
      cap_cnt <= '0;
      res_idx <= '0;
    end
  end

  // results survive the end of the run
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NN_HID_DIM; i++) begin
        res_mem[i] <= '0;
      end
    end else if (cap_hit) begin
      res_mem[res_idx] <= tree_sum + bus.bias;
    end
  end

  assign bus.bias_idx = res_idx;
  assign bus.valid = bus.run && (run_cnt == cnt_w'(last_cnt));

  genvar g;
  generate
    for (g = 0; g < `NN_HID_DIM; g++) begin : g_out
      assign results[g*`NN_N_LEN +: `NN_N_LEN] = res_mem[g];
    end
  endgenerate

endmodule

// ==== dense_layer_top.sv ====
`include "nn_cfg.svh"

module dense_layer_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                wr_en,
  input  logic [`NN_ADDR_W-1:0]               wr_addr,
  input  nn_pkg::fix_t                        wr_data,
  input  logic                                start,
  output logic                                busy,
  output logic                                done,
  output logic [`NN_HID_DIM*`NN_N_LEN-1:0]    data_out
);

  logic [$clog2(`NN_HID_DIM)-1:0] neuron_idx;
  logic [$clog2(`NN_CHUNKS)-1:0]  chunk_idx;

  layer_bus_if u_bus ();

  // weights, biases and inputs
  param_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .busy       (busy),
    .neuron_idx (neuron_idx),
    .chunk_idx  (chunk_idx),
    .bus        (u_bus.regs)
  );

  layer_sequencer u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .neuron_idx (neuron_idx),
    .chunk_idx  (chunk_idx),
    .bus        (u_bus.seq)
  );

  // multiply, reduce and store
  dense_core u_core (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus     (u_bus.core),
    .results (data_out)
  );

endmodule

// ==== tb_dense_layer.sv ====
`include "nn_cfg.svh"

module tb_dense_layer;

  localparam int n_w = `NN_IN_DIM * `NN_HID_DIM;
  localparam int done_latency = 103;
  localparam int done_timeout = 400;

  logic                             clk;
  logic                             rst_n;
  logic                             wr_en;
  logic [`NN_ADDR_W-1:0]            wr_addr;
  logic [`NN_N_LEN-1:0]             wr_data;
  logic                             start;
  logic                             busy;
  logic                             done;
  logic [`NN_HID_DIM*`NN_N_LEN-1:0] data_out;

  int seed;
  int flow_errors;
  int result_errors;
  int done_count;
  bit timed_out;

  // host-side copies of what the DUT should hold
  logic [15:0] w_ref [n_w];
  logic [15:0] b_ref [`NN_HID_DIM];
  logic [15:0] x_ref [`NN_IN_DIM];
  logic [15:0] exp_out [`NN_HID_DIM];
  logic [15:0] prev_out [`NN_HID_DIM];
  logic [15:0] old_bias [`NN_HID_DIM];

  dense_layer_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .data_out (data_out)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // truncated Q8.8 products, every sum wraps at 16 bits
  function automatic logic [15:0] ref_neuron(int n);
    logic [15:0] acc;
    logic signed [31:0] p;
    acc = b_ref[n];
    for (int i = 0; i < `NN_IN_DIM; i++) begin
      p = $signed(w_ref[n*`NN_IN_DIM+i]) * $signed(x_ref[i]);
      acc = acc + p[23:8];
    end
    return acc;
  endfunction

  task automatic write_word(input int addr, input logic [15:0] data);
    @(posedge clk);
    wr_en <= 1'b1;
    wr_addr <= `NN_ADDR_W'(addr);
    wr_data <= data;
  endtask

  task automatic load_params(input bit biases_only);
    for (int j = 0; j < `NN_HID_DIM; j++) begin
      write_word(`NN_BIAS_BASE + j, b_ref[j]);
    end
    if (!biases_only) begin
      for (int i = 0; i < n_w; i++) begin
        write_word(i, w_ref[i]);
      end
      for (int i = 0; i < `NN_IN_DIM; i++) begin
        write_word(`NN_INPUT_BASE + i, x_ref[i]);
      end
    end
    @(posedge clk);
    wr_en <= 1'b0;
    for (int j = 0; j < `NN_HID_DIM; j++) begin
      exp_out[j] = ref_neuron(j);
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < n_w; i++) begin
      w_ref[i] = 16'($random(seed));
    end
    for (int i = 0; i < `NN_IN_DIM; i++) begin
      x_ref[i] = 16'($random(seed));
      b_ref[i] = 16'($random(seed));
    end
  endtask

  // -1.0, near full scale and most negative values, so products overflow
  task automatic fill_directed();
    logic [15:0] w_set [4];
    logic [15:0] x_set [3];
    w_set = '{16'hff00, 16'h7fff, 16'h8000, 16'h0180};
    x_set = '{16'hff80, 16'h7fff, 16'h8001};
    for (int n = 0; n < `NN_HID_DIM; n++) begin
      for (int i = 0; i < `NN_IN_DIM; i++) begin
        w_ref[n*`NN_IN_DIM+i] = w_set[(n + i) % 4];
      end
      b_ref[n] = (n % 2 == 0) ? 16'h7f00 : 16'h8100;
    end
    for (int i = 0; i < `NN_IN_DIM; i++) begin
      x_ref[i] = x_set[i % 3];
    end
  endtask

  // disturb adds host writes and a second start while busy
  task automatic run_layer(input bit disturb);
    int c;
    int first_done;
    bit seen;
    c = 0;
    seen = 1'b0;
    first_done = done_count;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    if (busy !== 1'b1) begin
      flow_errors++;
      $display("error at time %0t: busy low one cycle after start", $time);
    end
    while (!seen && c < done_timeout) begin
      @(posedge clk);
      wr_en <= disturb && c >= 10 && c < 30;
      // odd cycles hit the input window, even cycles the weights
      wr_addr <= (c % 2 == 1) ? `NN_ADDR_W'(`NN_INPUT_BASE + c % `NN_IN_DIM)
                              : `NN_ADDR_W'((c * 37) % n_w);
      wr_data <= 16'($random(seed));
      start <= disturb && c == 15;
      c++;
      @(negedge clk);
      if (done === 1'b1) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      timed_out = 1'b1;
      $display("timed out: done did not come within %0d cycles of start", done_timeout);
    end else begin
      if (c != done_latency) begin
        flow_errors++;
        $display("error at time %0t: done after %0d cycles, expected %0d", $time, c,
                 done_latency);
      end
      @(negedge clk);
      if (done !== 1'b0 || busy !== 1'b0) begin
        flow_errors++;
        $display("error at time %0t: done or busy high after the done cycle", $time);
      end
      repeat (8) @(negedge clk);
      if (done_count != first_done + 1) begin
        flow_errors++;
        $display("error at time %0t: %0d done pulses in one run", $time,
                 done_count - first_done);
      end
    end
  endtask

  // every done gets a full check of data_out
  always @(negedge clk) begin
    if (done === 1'b1) begin
      done_count = done_count + 1;
      for (int j = 0; j < `NN_HID_DIM; j++) begin
        if (data_out[j*`NN_N_LEN +: `NN_N_LEN] !== exp_out[j]) begin
          result_errors = result_errors + 1;
          $display("error at time %0t: data_out[%0d] = %h, expected %h", $time, j,
                   data_out[j*`NN_N_LEN +: `NN_N_LEN], exp_out[j]);
        end
      end
    end
  end

  initial begin
    seed = 32'h61f2_0633;
    flow_errors = 0;
    result_errors = 0;
    done_count = 0;
    timed_out = 1'b0;
    rst_n <= 1'b0;
    wr_en <= 1'b0;
    wr_addr <= '0;
    wr_data <= '0;
    start <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (busy !== 1'b0 || done !== 1'b0 || data_out !== '0) begin
      flow_errors++;
      $display("error at time %0t: busy, done or data_out not clear after reset", $time);
    end

    fill_random();
    load_params(1'b0);
    run_layer(1'b0);

    // new data, then writes and start again while busy
    if (!timed_out) begin
      fill_random();
      load_params(1'b0);
      run_layer(1'b1);
    end

    // new biases only, on top of the weights and inputs above
    if (!timed_out) begin
      for (int j = 0; j < `NN_HID_DIM; j++) begin
        prev_out[j] = data_out[j*`NN_N_LEN +: `NN_N_LEN];
        old_bias[j] = b_ref[j];
        b_ref[j] = 16'($random(seed));
      end
      load_params(1'b1);
      @(negedge clk);
      for (int j = 0; j < `NN_HID_DIM; j++) begin
        if (data_out[j*`NN_N_LEN +: `NN_N_LEN] !== prev_out[j]) begin
          flow_errors++;
          $display("error at time %0t: data_out[%0d] changed between runs", $time, j);
        end
      end
      run_layer(1'b0);
      for (int j = 0; j < `NN_HID_DIM; j++) begin
        if (data_out[j*`NN_N_LEN +: `NN_N_LEN] !== 16'(prev_out[j] - old_bias[j] + b_ref[j]))
        begin
          flow_errors++;
          $display("error at time %0t: data_out[%0d] is not old sum plus new bias", $time, j);
        end
      end
    end

    if (!timed_out) begin
      fill_directed();
      load_params(1'b0);
      run_layer(1'b0);
    end

    $display("checks finished: %0d flow errors, %0d result errors, timeout %0d",
             flow_errors, result_errors, timed_out);
    if (!timed_out && flow_errors == 0 && result_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
nn_pkg.sv
layer_bus_if.sv
param_regs.sv
layer_sequencer.sv
dense_core.sv
dense_layer_top.sv
tb_dense_layer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the dense layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -Wno-fatal -f verilog.f --top-module tb_dense_layer \
  --Mdir obj_dir -o tb_dense_layer
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_dense_layer > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$log"; then
  echo "run passed"
  exit 0
else
  echo "run failed, see $log"
  exit 1
fi
